/* build.f */
logic/adapter_pkg.sv
logic/line_write_engine.sv
logic/line_read_engine.sv
logic/axi_adapter.sv
sim/axi_mem_model.sv
sim/tb_axi_adapter.sv

/* Makefile */
# Verilator build and run for the cache to AXI4 bridge

TOP := tb_axi_adapter

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/tb_axi_adapter.sv */
// testbench for the cache to AXI4 bridge
// runs a table of single and line requests against a shadow memory
`timescale 1ns/1ps

module tb_axi_adapter;

  localparam int NUM_TESTS = 10;

  typedef struct {
    string                  name;
    logic                   we;
    adapter_pkg::req_kind_e kind;
    logic [31:0]            addr;
    adapter_pkg::axi_size_t size;
    int unsigned            seed;
  } test_t;

  logic clk_i, rst_ni, req_i, we_i, gnt_o, valid_o, critical_word_valid_o;
  adapter_pkg::req_kind_e kind_i;
  logic [31:0] addr_i, aw_addr_o, ar_addr_o;
  adapter_pkg::axi_size_t size_i, aw_size_o, ar_size_o;
  adapter_pkg::line_t wdata_i, rdata_o;
  adapter_pkg::line_strb_t be_i;
  adapter_pkg::beat_t critical_word_o, w_data_o, r_data_i;
  adapter_pkg::strb_t w_strb_o;
  adapter_pkg::axi_len_t aw_len_o, ar_len_o;
  adapter_pkg::axi_resp_t b_resp_i, r_resp_i;
  logic aw_valid_o, aw_ready_i, w_valid_o, w_last_o, w_ready_i, b_valid_i, b_ready_o;
  logic ar_valid_o, ar_ready_i, r_valid_i, r_last_i, r_ready_o;

  test_t tests [NUM_TESTS];
  adapter_pkg::beat_t shadow [64];
  int err_cnt, pass_cnt, gnt_cnt, valid_cnt, cw_cnt;
  logic order_err;
  adapter_pkg::line_t rdata_seen;
  adapter_pkg::beat_t cw_seen;
  logic [31:0] aw_addr_seen, ar_addr_seen;
  adapter_pkg::axi_len_t aw_len_seen, ar_len_seen;
  adapter_pkg::axi_size_t aw_size_seen, ar_size_seen;

  axi_adapter u_axi_adapter (.*);

  axi_mem_model u_mem (
    .clk_i, .rst_ni,
    .aw_valid_i (aw_valid_o), .aw_addr_i (aw_addr_o), .aw_ready_o (aw_ready_i),
    .w_valid_i (w_valid_o), .w_data_i (w_data_o), .w_strb_i (w_strb_o),
    .w_last_i (w_last_o), .w_ready_o (w_ready_i),
    .b_valid_o (b_valid_i), .b_resp_o (b_resp_i), .b_ready_i (b_ready_o),
    .ar_valid_i (ar_valid_o), .ar_addr_i (ar_addr_o), .ar_len_i (ar_len_o),
    .ar_ready_o (ar_ready_i),
    .r_valid_o (r_valid_i), .r_data_o (r_data_i), .r_resp_o (r_resp_i),
    .r_last_o (r_last_i), .r_ready_i (r_ready_o)
  );

  always #2 clk_i = ~clk_i;

  function automatic int unsigned lcg_next(int unsigned s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // apply only the strobed bytes of a new beat
  function automatic adapter_pkg::beat_t merge_bytes(adapter_pkg::beat_t old_b,
      adapter_pkg::beat_t new_b, adapter_pkg::strb_t strb);
    adapter_pkg::beat_t res;
    res = old_b;
    for (int j = 0; j < 8; j++) begin
      if (strb[j]) res[8*j +: 8] = new_b[8*j +: 8];
    end
    return res;
  endfunction

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_line(string name, adapter_pkg::line_t exp, adapter_pkg::line_t act);
    if (exp !== act) begin
      err_cnt++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_beat(string name, adapter_pkg::beat_t exp, adapter_pkg::beat_t act);
    if (exp !== act) begin
      err_cnt++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_addr(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      err_cnt++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_len(string name, adapter_pkg::axi_len_t exp, adapter_pkg::axi_len_t act);
    if (exp !== act) begin
      err_cnt++;
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_size(string name, adapter_pkg::axi_size_t exp,
      adapter_pkg::axi_size_t act);
    if (exp !== act) begin
      err_cnt++;
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic report_fault(string what);
    err_cnt++;
    $display("%s", what);
  endtask

  // monitor samples mid-cycle where all outputs are settled
  always @(negedge clk_i) begin
    if (gnt_o) gnt_cnt++;
    if (valid_o) begin
      valid_cnt++;
      if (gnt_cnt == 0) order_err = 1'b1;
      rdata_seen = rdata_o;
    end
    if (critical_word_valid_o) begin
      cw_cnt++;
      cw_seen = critical_word_o;
    end
    if (aw_valid_o && aw_ready_i) begin
      aw_addr_seen = aw_addr_o;
      aw_len_seen  = aw_len_o;
      aw_size_seen = aw_size_o;
    end
    if (ar_valid_o && ar_ready_i) begin
      ar_addr_seen = ar_addr_o;
      ar_len_seen  = ar_len_o;
      ar_size_seen = ar_size_o;
    end
  end

  task automatic run_test(int i);
    adapter_pkg::line_t      wd;
    adapter_pkg::line_t      exp_line;
    adapter_pkg::line_strb_t be;
    int unsigned             s;
    int                      err0;
    logic                    is_line;
    logic [5:0]              idx;
    logic [5:0]              base;
    s = tests[i].seed;
    for (int b = 0; b < 4; b++) begin
      s = lcg_next(s);
      wd[b][63:32] = s;
      s = lcg_next(s);
      wd[b][31:0] = s;
      s = lcg_next(s);
      be[b] = s[23:16];
    end
    gnt_cnt   = 0;
    valid_cnt = 0;
    cw_cnt    = 0;
    order_err = 1'b0;
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= tests[i].we;
    kind_i  <= tests[i].kind;
    addr_i  <= tests[i].addr;
    size_i  <= tests[i].size;
    wdata_i <= wd;
    be_i    <= be;
    do @(negedge clk_i); while (!gnt_o);
    @(posedge clk_i);
    req_i <= 1'b0;
    while (valid_cnt == 0) @(negedge clk_i);
    // a few more cycles to catch stray pulses
    repeat (3) @(negedge clk_i);
    err0    = err_cnt;
    is_line = (tests[i].kind == adapter_pkg::KIND_LINE);
    idx     = tests[i].addr[8:3];
    base    = {tests[i].addr[8:5], 2'b00};
    if (gnt_cnt != 1) report_fault($sformatf("%s: %0d grants seen", tests[i].name, gnt_cnt));
    if (valid_cnt != 1) report_fault($sformatf("%s: %0d valids seen", tests[i].name, valid_cnt));
    if (order_err) report_fault($sformatf("%s: valid came before grant", tests[i].name));
    if (tests[i].we) begin
      check_addr({tests[i].name, " aw_addr"},
          is_line ? (tests[i].addr & 32'hffff_ffe0) : tests[i].addr, aw_addr_seen);
      check_len({tests[i].name, " aw_len"}, is_line ? 8'd3 : 8'd0, aw_len_seen);
      check_size({tests[i].name, " aw_size"}, is_line ? 3'd3 : tests[i].size, aw_size_seen);
      if (is_line) begin
        for (int b = 0; b < 4; b++) begin
          shadow[base + 6'(b)] = merge_bytes(shadow[base + 6'(b)], wd[b], be[b]);
        end
      end else begin
        shadow[idx] = merge_bytes(shadow[idx], wd[0], be[0]);
      end
    end else begin
      check_addr({tests[i].name, " ar_addr"},
          is_line ? (tests[i].addr & 32'hffff_ffe0) : tests[i].addr, ar_addr_seen);
      check_len({tests[i].name, " ar_len"}, is_line ? 8'd3 : 8'd0, ar_len_seen);
      check_size({tests[i].name, " ar_size"}, is_line ? 3'd3 : tests[i].size, ar_size_seen);
      if (is_line) begin
        for (int b = 0; b < 4; b++) exp_line[b] = shadow[base + 6'(b)];
        check_line({tests[i].name, " rdata"}, exp_line, rdata_seen);
        if (cw_cnt != 1) report_fault($sformatf("%s: %0d critical words", tests[i].name, cw_cnt));
        check_beat({tests[i].name, " critical word"}, shadow[idx], cw_seen);
      end else begin
        check_beat({tests[i].name, " rdata"}, shadow[idx], rdata_seen[0]);
        if (cw_cnt != 0) report_fault($sformatf("%s: critical word on single read", tests[i].name));
      end
    end
    if (err_cnt == err0) pass_cnt++;
    $display("%s: %s", tests[i].name, (err_cnt == err0) ? "ok" : "failed");
  endtask

  // watchdog
  initial begin
    repeat (NUM_TESTS * 200) @(posedge clk_i);
    $display("timeout: the run did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    tests[0] = '{"wr_single_48", 1'b1, adapter_pkg::KIND_SINGLE, 32'h48, 3'd2, 11};
    tests[1] = '{"rd_single_48", 1'b0, adapter_pkg::KIND_SINGLE, 32'h48, 3'd2, 0};
    tests[2] = '{"wr_line_80", 1'b1, adapter_pkg::KIND_LINE, 32'h80, 3'd0, 21};
    tests[3] = '{"rd_line_90", 1'b0, adapter_pkg::KIND_LINE, 32'h90, 3'd3, 0};
    tests[4] = '{"wr_line_1e0", 1'b1, adapter_pkg::KIND_LINE, 32'h1e0, 3'd3, 7};
    tests[5] = '{"rd_line_1f8", 1'b0, adapter_pkg::KIND_LINE, 32'h1f8, 3'd1, 0};
    tests[6] = '{"rd_line_20", 1'b0, adapter_pkg::KIND_LINE, 32'h20, 3'd3, 0};
    tests[7] = '{"wr_single_88", 1'b1, adapter_pkg::KIND_SINGLE, 32'h88, 3'd3, 4};
    tests[8] = '{"rd_line_88", 1'b0, adapter_pkg::KIND_LINE, 32'h88, 3'd3, 0};
    tests[9] = '{"rd_single_88", 1'b0, adapter_pkg::KIND_SINGLE, 32'h88, 3'd3, 0};
    // shadow starts with the memory fill pattern
    for (int i = 0; i < 64; i++) begin
      shadow[i] = {32'(i) * 32'h9e37_79b9, ~(32'(i) * 32'h85eb_ca6b)};
    end
    err_cnt = 0;
    pass_cnt = 0;
    gnt_cnt = 0;
    valid_cnt = 0;
    cw_cnt = 0;
    order_err = 1'b0;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    req_i = 1'b0;
    we_i = 1'b0;
    kind_i = adapter_pkg::KIND_SINGLE;
    addr_i = '0;
    size_i = '0;
    wdata_i = '0;
    be_i = '0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (2) @(negedge clk_i);
    if (gnt_o || valid_o || critical_word_valid_o || aw_valid_o || w_valid_o ||
        ar_valid_o || b_ready_o || r_ready_o) begin
      report_fault("idle_after_reset: an output is high with no request");
    end
    $display("idle_after_reset: %s", (err_cnt == 0) ? "ok" : "failed");
    for (int i = 0; i < NUM_TESTS; i++) run_test(i);
    $display("tests %0d, passed %0d, errors %0d", NUM_TESTS, pass_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* sim/axi_mem_model.sv */
// AXI subordinate memory of 64 beats with random ready and valid stalls
// takes one write and one read burst at a time
`timescale 1ns/1ps

module axi_mem_model (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               aw_valid_i,
  input  logic [31:0]        aw_addr_i,
  output logic               aw_ready_o,
  input  logic               w_valid_i,
  input  logic [63:0]        w_data_i,
  input  logic [7:0]         w_strb_i,
  input  logic               w_last_i,
  output logic               w_ready_o,
  output logic               b_valid_o,
  output logic [1:0]         b_resp_o,
  input  logic               b_ready_i,
  input  logic               ar_valid_i,
  input  logic [31:0]        ar_addr_i,
  input  logic [7:0]         ar_len_i,
  output logic               ar_ready_o,
  output logic               r_valid_o,
  output logic [63:0]        r_data_o,
  output logic [1:0]         r_resp_o,
  output logic               r_last_o,
  input  logic               r_ready_i
);

  logic [63:0] mem [64];
  logic [63:0] wbuf_data [4];
  logic [7:0]  wbuf_strb [4];
  logic [31:0] rnd_q;
  logic [5:0]  aw_idx_q, r_idx_q;
  logic [7:0]  r_len_q, r_cnt_q;
  logic [2:0]  w_cnt_q;
  logic        aw_done_q, w_done_q, b_pend_q, r_active_q;
  logic        aw_fire, w_fire, ar_fire;

  assign aw_fire  = aw_valid_i && aw_ready_o;
  assign w_fire   = w_valid_i && w_ready_o;
  assign ar_fire  = ar_valid_i && ar_ready_o;
  assign b_resp_o = 2'b00;
  assign r_resp_o = 2'b00;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < 64; i++) begin
        mem[i] <= {32'(i) * 32'h9e37_79b9, ~(32'(i) * 32'h85eb_ca6b)};
      end
      rnd_q      <= 32'd3;
      aw_ready_o <= 1'b0;
      w_ready_o  <= 1'b0;
      ar_ready_o <= 1'b0;
      b_valid_o  <= 1'b0;
      r_valid_o  <= 1'b0;
      r_data_o   <= '0;
      r_last_o   <= 1'b0;
      aw_idx_q   <= '0;
      r_idx_q    <= '0;
      r_len_q    <= '0;
      r_cnt_q    <= '0;
      w_cnt_q    <= '0;
      aw_done_q  <= 1'b0;
      w_done_q   <= 1'b0;
      b_pend_q   <= 1'b0;
      r_active_q <= 1'b0;
    end else begin
      rnd_q <= rnd_q * 32'd1103515245 + 32'd12345;
      aw_ready_o <= !(aw_done_q || aw_fire) && rnd_q[16];
      w_ready_o  <= !(w_done_q || (w_fire && w_last_i)) && rnd_q[17];
      ar_ready_o <= !(r_active_q || ar_fire) && rnd_q[19];
      // ------------------------------
      // write side
      // ------------------------------
      if (aw_fire) begin
        aw_done_q <= 1'b1;
        aw_idx_q  <= aw_addr_i[8:3];
      end
      if (w_fire) begin
        wbuf_data[w_cnt_q[1:0]] <= w_data_i;
        wbuf_strb[w_cnt_q[1:0]] <= w_strb_i;
        w_cnt_q <= w_cnt_q + 3'd1;
        if (w_last_i) w_done_q <= 1'b1;
      end
      // commit buffered beats once address and last beat are both in
      if (aw_done_q && w_done_q) begin
        for (int b = 0; b < 4; b++) begin
          for (int j = 0; j < 8; j++) begin
            if (3'(b) < w_cnt_q && wbuf_strb[b][j]) begin
              mem[aw_idx_q + 6'(b)][8*j +: 8] <= wbuf_data[b][8*j +: 8];
            end
          end
        end
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
        w_cnt_q   <= '0;
        b_pend_q  <= 1'b1;
      end
      if (b_valid_o && b_ready_i) begin
        b_valid_o <= 1'b0;
      end else if (b_pend_q && rnd_q[18]) begin
        b_valid_o <= 1'b1;
        b_pend_q  <= 1'b0;
      end
      // ------------------------------
      // read side
      // ------------------------------
      if (ar_fire) begin
        r_active_q <= 1'b1;
        r_idx_q    <= ar_addr_i[8:3];
        r_len_q    <= ar_len_i;
        r_cnt_q    <= '0;
      end
      if (r_valid_o && r_ready_i) begin
        r_valid_o <= 1'b0;
        if (r_last_o) r_active_q <= 1'b0;
        else r_cnt_q <= r_cnt_q + 8'd1;
      end else if (r_active_q && !r_valid_o && rnd_q[20]) begin
        r_valid_o <= 1'b1;
        r_data_o  <= mem[r_idx_q + r_cnt_q[5:0]];
        r_last_o  <= (r_cnt_q == r_len_q);
      end
    end
  end

endmodule

/* logic/axi_adapter.sv */
// cache to AXI4 bridge top level
// hands each request to the write or read engine and merges their handshakes
`timescale 1ns/1ps

module axi_adapter (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // cache side
  input  logic                           req_i,
  input  logic                           we_i,
  input  adapter_pkg::req_kind_e         kind_i,
  input  logic [adapter_pkg::ADDR_W-1:0] addr_i,
  input  adapter_pkg::axi_size_t         size_i,
  input  adapter_pkg::line_t             wdata_i,
  input  adapter_pkg::line_strb_t        be_i,
  output logic                           gnt_o,
  output logic                           valid_o,
  output adapter_pkg::line_t             rdata_o,
  output adapter_pkg::beat_t             critical_word_o,
  output logic                           critical_word_valid_o,
  // AW channel
  output logic                           aw_valid_o,
  output logic [adapter_pkg::ADDR_W-1:0] aw_addr_o,
  output adapter_pkg::axi_len_t          aw_len_o,
  output adapter_pkg::axi_size_t         aw_size_o,
  input  logic                           aw_ready_i,
  // W channel
  output logic                           w_valid_o,
  output adapter_pkg::beat_t             w_data_o,
  output adapter_pkg::strb_t             w_strb_o,
  output logic                           w_last_o,
  input  logic                           w_ready_i,
  // B channel
  input  logic                           b_valid_i,
  input  adapter_pkg::axi_resp_t         b_resp_i,
  output logic                           b_ready_o,
  // AR channel
  output logic                           ar_valid_o,
  output logic [adapter_pkg::ADDR_W-1:0] ar_addr_o,
  output adapter_pkg::axi_len_t          ar_len_o,
  output adapter_pkg::axi_size_t         ar_size_o,
  input  logic                           ar_ready_i,
  // R channel
  input  logic                           r_valid_i,
  input  adapter_pkg::beat_t             r_data_i,
  input  adapter_pkg::axi_resp_t         r_resp_i,
  input  logic                           r_last_i,
  output logic                           r_ready_o
);

  logic busy_q;
  logic start;
  logic wr_start, wr_gnt, wr_done, wr_busy;
  logic rd_start, rd_gnt, rd_done, rd_busy;

  // one request in flight between grant and completion
  assign start    = req_i && !busy_q;
  assign wr_start = start && we_i;
  assign rd_start = start && !we_i;

  assign gnt_o   = wr_gnt || rd_gnt;
  assign valid_o = wr_done || rd_done;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (valid_o) begin
      busy_q <= 1'b0;
    end else if (gnt_o) begin
      busy_q <= 1'b1;
    end
  end

  line_write_engine u_write (
    .clk_i, .rst_ni,
    .start_i (wr_start), .kind_i, .addr_i, .size_i, .wdata_i, .be_i,
    .gnt_o   (wr_gnt), .done_o (wr_done), .busy_o (wr_busy),
    .aw_valid_o, .aw_addr_o, .aw_len_o, .aw_size_o, .aw_ready_i,
    .w_valid_o, .w_data_o, .w_strb_o, .w_last_o, .w_ready_i,
    .b_valid_i, .b_resp_i, .b_ready_o
  );

  line_read_engine u_read (
    .clk_i, .rst_ni,
    .start_i (rd_start), .kind_i, .addr_i, .size_i,
    .gnt_o   (rd_gnt), .done_o (rd_done), .busy_o (rd_busy),
    .rdata_o, .critical_word_o, .critical_word_valid_o,
    .ar_valid_o, .ar_addr_o, .ar_len_o, .ar_size_o, .ar_ready_i,
    .r_valid_i, .r_data_i, .r_resp_i, .r_last_i, .r_ready_o
  );

  // a request is only ever steered to one engine at a time
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(wr_busy && rd_busy));

endmodule

/* logic/line_read_engine.sv */
// read engine, drives AR and R and assembles the returned cache line
// also flags the beat that holds the requested address
`timescale 1ns/1ps

module line_read_engine (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           start_i,
  input  adapter_pkg::req_kind_e         kind_i,
  input  logic [adapter_pkg::ADDR_W-1:0] addr_i,
  input  adapter_pkg::axi_size_t         size_i,
  output logic                           gnt_o,
  output logic                           done_o,
  output logic                           busy_o,
  output adapter_pkg::line_t             rdata_o,
  output adapter_pkg::beat_t             critical_word_o,
  output logic                           critical_word_valid_o,
  // AR channel
  output logic                           ar_valid_o,
  output logic [adapter_pkg::ADDR_W-1:0] ar_addr_o,
  output adapter_pkg::axi_len_t          ar_len_o,
  output adapter_pkg::axi_size_t         ar_size_o,
  input  logic                           ar_ready_i,
  // R channel
  input  logic                           r_valid_i,
  input  adapter_pkg::beat_t             r_data_i,
  input  adapter_pkg::axi_resp_t         r_resp_i,
  input  logic                           r_last_i,
  output logic                           r_ready_o
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_R,
    COMPLETE
  } state_e;

  state_e                 state_q, state_d;
  adapter_pkg::beat_idx_t cnt_q;
  adapter_pkg::beat_idx_t req_idx_q;
  logic                   line_kind_q;
  adapter_pkg::line_t     line_q;
  adapter_pkg::beat_idx_t last_idx;
  logic                   is_line;
  logic                   ar_fire, r_fire;

  assign is_line = (kind_i == adapter_pkg::KIND_LINE);

  // ------------------------------
  // AR request
  // ------------------------------
  // line reads start at the line base, single reads at the caller's address
  assign ar_valid_o = (state_q == IDLE) && start_i;
  assign ar_addr_o  = is_line ?
      {addr_i[adapter_pkg::ADDR_W-1:adapter_pkg::LINE_OFF_W], {adapter_pkg::LINE_OFF_W{1'b0}}} :
      addr_i;
  assign ar_len_o   = is_line ? adapter_pkg::LINE_LEN : '0;
  assign ar_size_o  = is_line ? adapter_pkg::LINE_SIZE : size_i;

  assign ar_fire = ar_valid_o && ar_ready_i;
  assign gnt_o   = ar_fire;

  // ------------------------------
  // R beats
  // ------------------------------
  assign r_ready_o = (state_q == WAIT_R);
  assign r_fire    = r_valid_i && r_ready_o;
  assign last_idx  = line_kind_q ? adapter_pkg::beat_idx_t'(adapter_pkg::LINE_BEATS - 1) : '0;

  assign critical_word_o       = r_data_i;
  assign critical_word_valid_o = r_fire && line_kind_q && (cnt_q == req_idx_q);

  assign rdata_o = line_q;
  assign done_o  = (state_q == COMPLETE);
  assign busy_o  = (state_q != IDLE);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:     if (ar_fire) state_d = WAIT_R;
      WAIT_R:   if (r_fire && r_last_i) state_d = COMPLETE;
      COMPLETE: state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      cnt_q       <= '0;
      req_idx_q   <= '0;
      line_kind_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (ar_fire) begin
        req_idx_q   <= addr_i[adapter_pkg::BYTE_OFF_W +: adapter_pkg::BEAT_IDX_W];
        line_kind_q <= is_line;
        cnt_q       <= '0;
      end else if (r_fire) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // line buffer, a single read only ever fills beat 0
  always_ff @(posedge clk_i) begin
    if (r_fire) line_q[cnt_q] <= r_data_i;
  end

  // last flag from the subordinate matches the burst length sent on AR
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_fire |-> r_last_i == (cnt_q == last_idx));

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_fire |-> r_resp_i == adapter_pkg::RESP_OKAY);

endmodule

/* logic/line_write_engine.sv */
// write engine, drives AW, W and B for single and full line writes
// grants once the address and the last data beat have both been taken
`timescale 1ns/1ps

module line_write_engine (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           start_i,
  input  adapter_pkg::req_kind_e         kind_i,
  input  logic [adapter_pkg::ADDR_W-1:0] addr_i,
  input  adapter_pkg::axi_size_t         size_i,
  input  adapter_pkg::line_t             wdata_i,
  input  adapter_pkg::line_strb_t        be_i,
  output logic                           gnt_o,
  output logic                           done_o,
  output logic                           busy_o,
  // AW channel
  output logic                           aw_valid_o,
  output logic [adapter_pkg::ADDR_W-1:0] aw_addr_o,
  output adapter_pkg::axi_len_t          aw_len_o,
  output adapter_pkg::axi_size_t         aw_size_o,
  input  logic                           aw_ready_i,
  // W channel
  output logic                           w_valid_o,
  output adapter_pkg::beat_t             w_data_o,
  output adapter_pkg::strb_t             w_strb_o,
  output logic                           w_last_o,
  input  logic                           w_ready_i,
  // B channel
  input  logic                           b_valid_i,
  input  adapter_pkg::axi_resp_t         b_resp_i,
  output logic                           b_ready_o
);

  typedef enum logic [2:0] {
    IDLE,
    SEND_W_AW,  // W beats going out, AW still open
    SEND_W,     // AW taken, W beats remain
    WAIT_AW,    // final W taken, AW still open
    WAIT_B
  } state_e;

  state_e                 state_q, state_d;
  adapter_pkg::beat_idx_t cnt_q, cnt_d;
  adapter_pkg::beat_idx_t last_idx;
  logic                   is_line;
  logic                   both_open;
  logic                   aw_fire, w_fire;

  assign is_line   = (kind_i == adapter_pkg::KIND_LINE);
  assign last_idx  = is_line ? adapter_pkg::beat_idx_t'(adapter_pkg::LINE_BEATS - 1) : '0;
  // the idle state already presents AW and the first beat on start
  assign both_open = (state_q == IDLE && start_i) || (state_q == SEND_W_AW);

  // ------------------------------
  // channel outputs
  // ------------------------------
  assign aw_valid_o = both_open || (state_q == WAIT_AW);
  assign aw_addr_o  = is_line ?
      {addr_i[adapter_pkg::ADDR_W-1:adapter_pkg::LINE_OFF_W], {adapter_pkg::LINE_OFF_W{1'b0}}} :
      addr_i;
  assign aw_len_o   = is_line ? adapter_pkg::LINE_LEN : '0;
  assign aw_size_o  = is_line ? adapter_pkg::LINE_SIZE : size_i;

  assign w_valid_o = both_open || (state_q == SEND_W);
  assign w_data_o  = wdata_i[cnt_q];
  assign w_strb_o  = be_i[cnt_q];
  assign w_last_o  = w_valid_o && (cnt_q == last_idx);

  assign b_ready_o = (state_q == WAIT_B) && b_valid_i;

  assign aw_fire = aw_valid_o && aw_ready_i;
  assign w_fire  = w_valid_o && w_ready_i;
  assign done_o  = b_ready_o;
  assign busy_o  = (state_q != IDLE);

  always_comb begin
    state_d = state_q;
    gnt_o   = 1'b0;
    unique case (state_q)
      IDLE, SEND_W_AW: begin
        if (both_open) begin
          if (aw_fire && w_fire && w_last_o) begin
            state_d = WAIT_B;
            gnt_o   = 1'b1;
          end else if (aw_fire) begin
            state_d = SEND_W;
          end else if (w_fire && w_last_o) begin
            state_d = WAIT_AW;
          end else begin
            state_d = SEND_W_AW;
          end
        end
      end
      SEND_W: begin
        if (w_fire && w_last_o) begin
          state_d = WAIT_B;
          gnt_o   = 1'b1;
        end
      end
      WAIT_AW: begin
        if (aw_fire) begin
          state_d = WAIT_B;
          gnt_o   = 1'b1;
        end
      end
      WAIT_B: begin
        if (b_ready_o) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  // beat counter, wraps back to zero after the last beat
  always_comb begin
    cnt_d = cnt_q;
    if (w_fire) cnt_d = w_last_o ? '0 : cnt_q + 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // AW request holds with its address until the subordinate takes it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o));

  // the beat marked last closes the W burst
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_fire && w_last_o |=> !w_valid_o);

  // subordinate only ever answers OKAY
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_ready_o |-> b_resp_i == adapter_pkg::RESP_OKAY);

endmodule

/* logic/adapter_pkg.sv */
// shared widths, cache line geometry and AXI encodings
// for the cache to AXI4 bridge
package adapter_pkg;

  // ------------------------------
  // bus widths and line geometry
  // ------------------------------
  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned BEAT_W     = 64;
  localparam int unsigned STRB_W     = BEAT_W / 8;
  localparam int unsigned LINE_BEATS = 4;
  localparam int unsigned BEAT_IDX_W = 2;
  // byte offset inside one beat, then inside the whole line
  localparam int unsigned BYTE_OFF_W = 3;
  localparam int unsigned LINE_OFF_W = BYTE_OFF_W + BEAT_IDX_W;

  // ------------------------------
  // data and AXI field types
  // ------------------------------
  typedef logic [BEAT_W-1:0]     beat_t;
  typedef logic [STRB_W-1:0]     strb_t;
  typedef beat_t [LINE_BEATS-1:0] line_t;
  typedef strb_t [LINE_BEATS-1:0] line_strb_t;
  typedef logic [BEAT_IDX_W-1:0] beat_idx_t;

  typedef logic [7:0] axi_len_t;
  typedef logic [2:0] axi_size_t;
  typedef logic [1:0] axi_resp_t;

  typedef enum logic {
    KIND_SINGLE = 1'b0,
    KIND_LINE   = 1'b1
  } req_kind_e;

  // a line burst is LINE_BEATS full-width beats
  localparam axi_len_t  LINE_LEN  = axi_len_t'(LINE_BEATS - 1);
  localparam axi_size_t LINE_SIZE = 3'd3;
  localparam axi_resp_t RESP_OKAY = 2'b00;

endpackage
